/* logic/blimp_defines.svh */
/*
 * Blimp execute slice configuration
 * Widths, lane count, queue sizing and multiplier iteration count,
 * shared by the packages and the RTL
 */

`ifndef BLIMP_DEFINES_SVH
`define BLIMP_DEFINES_SVH

// ------------------------------------------------
// Datapath
// ------------------------------------------------

`define BLIMP_XLEN        32  // Data word width

// ------------------------------------------------
// Microarchitecture sizing
// ------------------------------------------------

`define BLIMP_NUM_PIPES   4   // Identical execute lanes

// Program-order tag width, sets ROB size and in-flight limit
`define BLIMP_SEQ_BITS    4

`define BLIMP_ISSUE_DEPTH 8   // Issue queue entries, power of two

// Shift-add iterations, 2 multiplier bits each
`define BLIMP_MUL_STEPS   16

`endif

/* logic/blimp_arch_pkg.sv */
/*
 * Blimp architectural types
 * Opcodes of the register-to-register operations, data word and
 * destination register address
 */

`default_nettype none

`include "blimp_defines.svh"

package blimp_arch_pkg;

  // ------------------------------------------------
  // Operations
  // ------------------------------------------------

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // Wrapping add
    OP_SUB = 3'd1,  // Wrapping subtract
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4   // Low word of product
  } opcode_e;

  // ------------------------------------------------
  // Operands and destinations
  // ------------------------------------------------

  typedef logic [`BLIMP_XLEN-1:0] word_t;

  typedef logic [4:0] reg_addr_t;  // 32 architectural registers

endpackage

`default_nettype wire

/* logic/blimp_uarch_pkg.sv */
/*
 * Blimp microarchitectural types
 * Program-order tag and execute lane states
 */

`default_nettype none

`include "blimp_defines.svh"

package blimp_uarch_pkg;

  // Tag given at issue, indexes the ROB
  typedef logic [`BLIMP_SEQ_BITS-1:0] seq_num_t;

  // Lane FSM states
  typedef enum logic [1:0] {
    PIPE_IDLE = 2'd0,  // Free for dispatch
    PIPE_ALU  = 2'd1,  // Single-cycle op, result ready
    PIPE_MUL  = 2'd2   // Iterating multiply
  } pipe_state_e;

endpackage

`default_nettype wire

/* logic/blimp_intfs.sv */
/*
 * Blimp internal interfaces
 * issue_pipe_if carries a dispatched operation to one lane,
 * pipe_wb_if carries a lane's completion to the ROB
 */

`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------
// Issue unit to execute lane
// ------------------------------------------------

interface issue_pipe_if import blimp_arch_pkg::*, blimp_uarch_pkg::*; ();

  logic      val;    // One-cycle dispatch strobe
  seq_num_t  seq;
  opcode_e   op;
  reg_addr_t waddr;
  word_t     op_a;
  word_t     op_b;
  logic      idle;   // Lane can take an op this cycle

  modport issue (
    output val, seq, op, waddr, op_a, op_b,
    input  idle
  );

  modport pipe (
    input  val, seq, op, waddr, op_a, op_b,
    output idle
  );

endinterface

// ------------------------------------------------
// Execute lane to writeback/commit
// ------------------------------------------------

interface pipe_wb_if import blimp_arch_pkg::*, blimp_uarch_pkg::*; ();

  logic      val;    // Completion strobe, never stalled
  seq_num_t  seq;    // ROB slot
  reg_addr_t waddr;
  word_t     wdata;

  modport pipe (output val, seq, waddr, wdata);
  modport wb   (input  val, seq, waddr, wdata);

endinterface

`default_nettype wire

/* logic/issue_unit.sv */
/*
 * Issue unit
 * Tags accepted ops with sequence numbers, queues them in order and
 * hands the queue head to the lowest-numbered idle lane
 */

`timescale 1ns/1ps
`default_nettype none

`include "blimp_defines.svh"

module issue_unit import blimp_arch_pkg::*, blimp_uarch_pkg::*; (
  input  logic               clk,
  input  logic               rst,

  input  logic               in_val,
  input  opcode_e            in_op,
  input  reg_addr_t          in_waddr,
  input  word_t              in_op_a,
  input  word_t              in_op_b,
  input  logic               commit_val,  // One retirement per strobe

  output logic               full,

  issue_pipe_if.issue        pipes [`BLIMP_NUM_PIPES]
);

  localparam int p_ptr_bits = $clog2(`BLIMP_ISSUE_DEPTH);
  localparam int p_cnt_bits = p_ptr_bits + 1;
  localparam logic [p_cnt_bits-1:0] p_q_depth = p_cnt_bits'(`BLIMP_ISSUE_DEPTH);
  localparam logic [`BLIMP_SEQ_BITS:0] p_max_in_flight = {1'b1, {`BLIMP_SEQ_BITS{1'b0}}};

  // Queue storage, payload only
  opcode_e   q_op    [`BLIMP_ISSUE_DEPTH];
  seq_num_t  q_seq   [`BLIMP_ISSUE_DEPTH];
  reg_addr_t q_waddr [`BLIMP_ISSUE_DEPTH];
  word_t     q_op_a  [`BLIMP_ISSUE_DEPTH];
  word_t     q_op_b  [`BLIMP_ISSUE_DEPTH];

  logic [p_ptr_bits-1:0] wr_ptr;
  logic [p_ptr_bits-1:0] rd_ptr;
  logic [p_cnt_bits-1:0] q_count;
  logic [`BLIMP_SEQ_BITS:0] in_flight;  // Accepted but not yet committed
  seq_num_t next_seq;

  logic accept;
  logic q_nonempty;
  logic pop;
  logic [`BLIMP_NUM_PIPES-1:0] pipe_idle;
  logic [`BLIMP_NUM_PIPES-1:0] disp_grant;  // One-hot, lowest idle lane

  // ------------------------------------------------
  // Accept and back-pressure
  // ------------------------------------------------

  assign full   = (q_count == p_q_depth) || (in_flight == p_max_in_flight);
  assign accept = in_val && !full;  // Offers while full are dropped

  always_ff @(posedge clk) begin
    if (accept) begin
      q_op[wr_ptr]    <= in_op;
      q_seq[wr_ptr]   <= next_seq;  // Tag in program order
      q_waddr[wr_ptr] <= in_waddr;
      q_op_a[wr_ptr]  <= in_op_a;
      q_op_b[wr_ptr]  <= in_op_b;
    end
  end

  // ------------------------------------------------
  // Dispatch
  // ------------------------------------------------

  assign q_nonempty = (q_count != '0);
  assign disp_grant = pipe_idle & (~pipe_idle + 1'b1);  // Isolate lowest set bit
  assign pop        = q_nonempty && (|pipe_idle);

  for (genvar p = 0; p < `BLIMP_NUM_PIPES; p++) begin : g_lane
    assign pipe_idle[p]   = pipes[p].idle;
    assign pipes[p].val   = q_nonempty && disp_grant[p];
    // Head broadcast to every lane, val picks one
    assign pipes[p].seq   = q_seq[rd_ptr];
    assign pipes[p].op    = q_op[rd_ptr];
    assign pipes[p].waddr = q_waddr[rd_ptr];
    assign pipes[p].op_a  = q_op_a[rd_ptr];
    assign pipes[p].op_b  = q_op_b[rd_ptr];
  end

  // ------------------------------------------------
  // Pointers and counters
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      q_count   <= '0;
      in_flight <= '0;
      next_seq  <= '0;
    end else begin
      if (accept) begin
        wr_ptr   <= wr_ptr + 1'b1;
        next_seq <= next_seq + 1'b1;  // Wraps with the ROB
      end
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;

      case ({accept, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;  // Both or neither
      endcase

      case ({accept, commit_val})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/exec_pipe.sv */
/*
 * Execute lane
 * One-cycle ADD/SUB/AND/XOR and a 2-bit-per-cycle shift-add multiplier,
 * result sent to writeback with its tag and destination
 */

`timescale 1ns/1ps
`default_nettype none

`include "blimp_defines.svh"

module exec_pipe import blimp_arch_pkg::*, blimp_uarch_pkg::*; (
  input logic        clk,
  input logic        rst,

  issue_pipe_if.pipe issue,
  pipe_wb_if.pipe    wb
);

  localparam int p_step_bits = $clog2(`BLIMP_MUL_STEPS);
  localparam logic [p_step_bits-1:0] p_last_step = p_step_bits'(`BLIMP_MUL_STEPS - 1);

  pipe_state_e state;
  seq_num_t    seq_q;
  reg_addr_t   waddr_q;
  word_t       acc;     // ALU result or running product
  word_t       mcand;   // Multiplicand, pre-shifted
  word_t       mplier;  // Unconsumed multiplier bits
  logic [p_step_bits-1:0] step;

  word_t alu_res;
  logic  dispatch;
  logic  mul_done;

  // Product of a word and two multiplier bits
  function automatic word_t mul_partial(word_t a, logic [1:0] b);
    word_t p;
    p = b[0] ? a : '0;
    if (b[1])
      p = p + {a[`BLIMP_XLEN-2:0], 1'b0};
    return p;
  endfunction

  assign dispatch = (state == PIPE_IDLE) && issue.val;
  assign mul_done = (state == PIPE_MUL) && (step == p_last_step);

  always_comb begin
    case (issue.op)
      OP_ADD:  alu_res = issue.op_a + issue.op_b;
      OP_SUB:  alu_res = issue.op_a - issue.op_b;
      OP_AND:  alu_res = issue.op_a & issue.op_b;
      OP_XOR:  alu_res = issue.op_a ^ issue.op_b;
      default: alu_res = '0;  // MUL goes through acc
    endcase
  end

  // ------------------------------------------------
  // Lane FSM
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= PIPE_IDLE;
    end else begin
      case (state)
        PIPE_IDLE: if (dispatch) state <= (issue.op == OP_MUL) ? PIPE_MUL : PIPE_ALU;
        PIPE_ALU:  state <= PIPE_IDLE;        // Result leaves this cycle
        PIPE_MUL:  if (mul_done) state <= PIPE_IDLE;
        default:   state <= PIPE_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (dispatch) begin
      seq_q   <= issue.seq;
      waddr_q <= issue.waddr;
      step    <= '0;
      mcand   <= issue.op_a << 2;
      mplier  <= issue.op_b >> 2;
      // First multiplier pair folded into the dispatch edge
      acc     <= (issue.op == OP_MUL) ? mul_partial(issue.op_a, issue.op_b[1:0]) : alu_res;
    end else if ((state == PIPE_MUL) && !mul_done) begin
      acc    <= acc + mul_partial(mcand, mplier[1:0]);
      mcand  <= mcand << 2;
      mplier <= mplier >> 2;
      step   <= step + 1'b1;
    end
  end

  assign issue.idle = (state == PIPE_IDLE);

  assign wb.val   = (state == PIPE_ALU) || mul_done;
  assign wb.seq   = seq_q;
  assign wb.waddr = waddr_q;
  assign wb.wdata = acc;

endmodule

`default_nettype wire

/* logic/writeback_commit_unit.sv */
/*
 * Writeback and commit unit
 * Reorder buffer indexed by sequence number, filled out of order by
 * all lanes, drained one entry per cycle in program order
 */

`timescale 1ns/1ps
`default_nettype none

`include "blimp_defines.svh"

module writeback_commit_unit import blimp_arch_pkg::*, blimp_uarch_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  pipe_wb_if.wb     wbs [`BLIMP_NUM_PIPES],

  output logic      commit_val,
  output seq_num_t  commit_seq,
  output reg_addr_t commit_waddr,
  output word_t     commit_wdata
);

  localparam int p_rob_size = 1 << `BLIMP_SEQ_BITS;

  // Flattened lane completions
  logic [`BLIMP_NUM_PIPES-1:0] wb_val;
  seq_num_t  wb_seq   [`BLIMP_NUM_PIPES];
  reg_addr_t wb_waddr [`BLIMP_NUM_PIPES];
  word_t     wb_wdata [`BLIMP_NUM_PIPES];

  // ROB
  logic [p_rob_size-1:0] rob_done;
  reg_addr_t rob_waddr [p_rob_size];
  word_t     rob_wdata [p_rob_size];

  seq_num_t head;        // Oldest uncommitted tag
  logic     head_ready;

  for (genvar p = 0; p < `BLIMP_NUM_PIPES; p++) begin : g_lane
    assign wb_val[p]   = wbs[p].val;
    assign wb_seq[p]   = wbs[p].seq;
    assign wb_waddr[p] = wbs[p].waddr;
    assign wb_wdata[p] = wbs[p].wdata;
  end

  assign head_ready = rob_done[head];

  // ------------------------------------------------
  // Completion writes
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rob_done <= '0;
    end else begin
      if (head_ready)
        rob_done[head] <= 1'b0;  // Retiring slot freed
      // Tags in flight are unique, lanes never collide
      for (int p = 0; p < `BLIMP_NUM_PIPES; p++) begin
        if (wb_val[p])
          rob_done[wb_seq[p]] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `BLIMP_NUM_PIPES; p++) begin
      if (wb_val[p]) begin
        rob_waddr[wb_seq[p]] <= wb_waddr[p];
        rob_wdata[wb_seq[p]] <= wb_wdata[p];
      end
    end
  end

  // ------------------------------------------------
  // In-order commit
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      head       <= '0;
      commit_val <= 1'b0;
    end else begin
      commit_val <= head_ready;  // Registered strobe
      if (head_ready)
        head <= head + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit_seq   <= head;
      commit_waddr <= rob_waddr[head];
      commit_wdata <= rob_wdata[head];
    end
  end

endmodule

`default_nettype wire

/* logic/blimp_exec_core.sv */
/*
 * Blimp execute core
 * Issue unit, a row of identical execute lanes and the
 * writeback/commit unit
 */

`timescale 1ns/1ps
`default_nettype none

`include "blimp_defines.svh"

module blimp_exec_core import blimp_arch_pkg::*, blimp_uarch_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Decoded ops with operands read
  input  logic      in_val,
  input  opcode_e   in_op,
  input  reg_addr_t in_waddr,
  input  word_t     in_op_a,
  input  word_t     in_op_b,
  output logic      full,     // Hold off in_val while high

  // Retirement, program order
  output logic      commit_val,
  output seq_num_t  commit_seq,
  output reg_addr_t commit_waddr,
  output word_t     commit_wdata
);

  // ------------------------------------------------
  // Interfaces
  // ------------------------------------------------

  issue_pipe_if issue_ifs [`BLIMP_NUM_PIPES] ();
  pipe_wb_if    wb_ifs    [`BLIMP_NUM_PIPES] ();

  // ------------------------------------------------
  // Units
  // ------------------------------------------------

  issue_unit iu (
    .pipes (issue_ifs),
    .*                    // commit_val fed back for in-flight count
  );

  for (genvar p = 0; p < `BLIMP_NUM_PIPES; p++) begin : g_pipe
    exec_pipe xu (
      .clk   (clk),
      .rst   (rst),
      .issue (issue_ifs[p]),
      .wb    (wb_ifs[p])
    );
  end

  writeback_commit_unit wcu (
    .wbs (wb_ifs),
    .*
  );

endmodule

`default_nettype wire

/* sim/tb_blimp_exec_core.sv */
/*
 * Testbench for the blimp execute core
 * Replays file vectors and a seeded random mix and checks every commit
 * for data, register, tag and program order
 */

`timescale 1ns/1ps
`default_nettype none

`include "blimp_defines.svh"

module tb_blimp_exec_core import blimp_arch_pkg::*; ();

  localparam int p_num_vecs      = 28;   // Lines of data in the vector file
  localparam int p_num_random    = 40;
  localparam int p_full_timeout  = 200;  // Several multiplies deep
  localparam int p_drain_timeout = 2000;

  logic      clk;
  logic      rst;
  logic      in_val;
  opcode_e   in_op;
  reg_addr_t in_waddr;
  word_t     in_op_a;
  word_t     in_op_b;
  logic      full;
  logic      commit_val;
  logic [`BLIMP_SEQ_BITS-1:0] commit_seq;
  reg_addr_t commit_waddr;
  word_t     commit_wdata;

  logic [31:0] vec_mem [p_num_vecs*5];  // opcode, op_a, op_b, waddr, result

  word_t     exp_data [$];  // Program order
  reg_addr_t exp_waddr [$];
  logic [`BLIMP_SEQ_BITS-1:0] exp_seq;
  logic      full_seen;
  integer    seed;

  blimp_exec_core blimp_exec_core_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // ------------------------------------------------
  // Reporting and reference model
  // ------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
      abort_run($sformatf("MISMATCH at time %0t: %s got %h expected %h",
                          $time, what, actual, expected));
  endtask

  // Result by opcode rule
  function automatic word_t model_result(opcode_e op, word_t a, word_t b);
    logic [63:0] prod;
    prod = 64'(a) * 64'(b);
    case (op)
      OP_ADD:  return a + b;      // Wraps at 32 bits
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return prod[31:0];  // Low word only
      default: return '0;
    endcase
  endfunction

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  // Offer one op on the next falling edge once full is low
  task automatic send_op(input opcode_e op, input word_t a, input word_t b,
                         input reg_addr_t waddr, input word_t expected);
    int waited;
    waited = 0;
    @(negedge clk);
    while (full) begin
      in_val = 1'b0;  // Hold off
      if (waited >= p_full_timeout)
        abort_run("Timed out waiting for full to go low before an input");
      waited++;
      @(negedge clk);
    end
    in_val   = 1'b1;
    in_op    = op;
    in_op_a  = a;
    in_op_b  = b;
    in_waddr = waddr;
    exp_data.push_back(expected);
    exp_waddr.push_back(waddr);
  endtask

  task automatic release_input();
    @(negedge clk);
    in_val = 1'b0;
  endtask

  task automatic drain(input string phase);
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      if (waited >= p_drain_timeout)
        abort_run($sformatf("Timed out waiting for all commits of the %s", phase));
      waited++;
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------
  // Commit monitor
  // ------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      exp_seq   = '0;
      full_seen = 1'b0;
    end else begin
      if (full)
        full_seen = 1'b1;
      if (commit_val) begin
        if (exp_data.size() == 0) begin
          abort_run("A commit arrived with no operation outstanding");
        end else begin
          check_value(32'(commit_seq), 32'(exp_seq), "commit_seq");
          check_value(32'(commit_waddr), 32'(exp_waddr[0]), "commit_waddr");
          check_value(commit_wdata, exp_data[0], "commit_wdata");
          void'(exp_data.pop_front());
          void'(exp_waddr.pop_front());
          exp_seq = exp_seq + 1'b1;  // Wraps at 16
        end
      end
    end
  end

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin
    int        i;
    logic [31:0] r;
    opcode_e   op;
    word_t     a;
    word_t     b;
    reg_addr_t waddr;

    seed       = 32'h0b278675;
    rst        = 1'b1;
    in_val     = 1'b0;
    in_op      = OP_ADD;
    in_waddr   = '0;
    in_op_a    = '0;
    in_op_b    = '0;

    $readmemh("sim/exec_vectors.txt", vec_mem);
    if (^vec_mem[p_num_vecs*5-1] === 1'bx)
      abort_run("Vector file sim/exec_vectors.txt is missing or too short");

    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Quiet core after reset
    repeat (10) begin
      @(negedge clk);
      check_value(32'(commit_val), 32'd0, "commit_val while idle");
      check_value(32'(full), 32'd0, "full while idle");
    end

    // File vectors back to back ending in a multiply burst
    for (i = 0; i < p_num_vecs; i++)
      send_op(opcode_e'(vec_mem[5*i][2:0]), vec_mem[5*i+1], vec_mem[5*i+2],
              vec_mem[5*i+3][4:0], vec_mem[5*i+4]);
    release_input();
    drain("vector file");
    check_value(32'(full_seen), 32'd1, "full raised by multiply burst");

    // Seeded random mix
    for (i = 0; i < p_num_random; i++) begin
      r     = $random(seed);
      op    = opcode_e'(3'(r % 32'd5));
      a     = $random(seed);
      b     = $random(seed);
      r     = $random(seed);
      waddr = r[4:0];
      send_op(op, a, b, waddr, model_result(op, a, b));
    end
    release_input();
    drain("random mix");

    repeat (5) @(negedge clk);  // Catch stray commits

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/exec_vectors.txt */
// opcode op_a op_b waddr expected_result, all hex
// opcode 0 ADD, 1 SUB, 2 AND, 3 XOR, 4 MUL
0 00000005 00000003 01 00000008
0 ffffffff 00000002 02 00000001
1 00000003 00000005 03 fffffffe
1 80000000 00000001 04 7fffffff
2 f0f0a5a5 0ff05aff 05 00f000a5
3 f0f0a5a5 0ff05aff 06 ff00ff5a
4 00000007 00000006 07 0000002a
4 80000001 00000003 08 80000003
4 ffffffff ffffffff 09 00000001
4 12345678 00000010 0a 23456780
4 0000ffff 0000ffff 0b fffe0001
0 00000010 00000020 0c 00000030
3 0000000f 000000ff 0d 000000f0
1 00000064 00000001 0e 00000063
2 ffffffff 12345678 0f 12345678
4 00000002 00000003 10 00000006
4 00000004 00000005 11 00000014
4 00000006 00000007 12 0000002a
4 00000008 00000009 13 00000048
4 0000000a 0000000b 14 0000006e
4 0000000c 0000000d 15 0000009c
4 0000000e 0000000f 16 000000d2
4 00000010 00000011 17 00000110
4 00000100 00000100 18 00010000
4 00010000 00010000 19 00000000
4 deadbeef 00000001 1a deadbeef
4 00000001 deadbeef 1b deadbeef
4 fffffffe 00000002 1c fffffffc

/* list.f */
+incdir+logic
logic/blimp_arch_pkg.sv
logic/blimp_uarch_pkg.sv
logic/blimp_intfs.sv
logic/issue_unit.sv
logic/exec_pipe.sv
logic/writeback_commit_unit.sv
logic/blimp_exec_core.sv
sim/tb_blimp_exec_core.sv

/* run.sh */
#!/bin/sh
# Build the blimp execute core testbench with Verilator and run it.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_blimp_exec_core

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f list.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./obj_dir/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi
